//--- src/apu_defs.svh
`ifndef APU_DEFS_SVH
`define APU_DEFS_SVH

// ------------------------------------------------------------
// Register port

`define AXIL_ADDR_W   8
`define AXIL_DATA_W   32

// Bytes decoded by the AOUT register block
`define AOUT_REG_SPAN 'h10

// ------------------------------------------------------------
// Sample path and generator

`define SAMPLE_W      16
`define FIFO_ADDR_W   2
`define FIFO_DEPTH    (1 << `FIFO_ADDR_W)
// Level runs 0..depth, so one bit more than the index
`define FIFO_LEVEL_W  (`FIFO_ADDR_W + 1)

`define INTERVAL_W    8
`define PWM_BITS      8
`define IRQLEVEL_W    3

`endif

//--- src/apu_pkg.sv
`include "apu_defs.svh"

package apu_pkg;

    // Byte offsets of the AOUT registers
    // CSR bits: 0 enable, 1 signed, 2 running (ro), 3 rdy (ro), 6:4 flevel (ro)
    // FIFO is write only and reads back as zero
    typedef enum logic [`AXIL_ADDR_W-1:0] {
        REG_CSR      = 'h00,
        REG_INTERVAL = 'h04,
        REG_IRQLEVEL = 'h08,
        REG_FIFO     = 'h0c
    } aout_reg_e;

    // Generator states
    // IDLE holds the output low, FETCH takes one sample, PLAY counts periods
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        PLAY
    } aout_state_e;

endpackage

//--- src/axil_slave_port.sv
`include "apu_defs.svh"

module axil_slave_port
    import apu_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        rst_n_sys,
    input  logic [`AXIL_ADDR_W-1:0]     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXIL_DATA_W-1:0]     wdata,
    input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXIL_ADDR_W-1:0]     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`AXIL_DATA_W-1:0]     rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        reg_wr,
    output logic                        reg_rd,
    output aout_reg_e                   reg_addr,
    output logic [`AXIL_DATA_W-1:0]     reg_wdata,
    input  logic [`AXIL_DATA_W-1:0]     reg_rdata,
    input  logic                        reg_err
);

    localparam int         STRB_W      = `AXIL_DATA_W / 8;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic              port_en;
    logic              busy;
    logic              aw_held;
    logic              w_held;
    logic              acc_q;
    logic              acc_wr_q;
    logic [STRB_W-1:0] strb_q;
    logic              aw_fire;
    logic              w_fire;
    logic              ar_fire;
    logic              wr_go;
    logic              strb_full;
    logic              resp_done;

    // ------------------------------------------------------------
    // Handshakes

    // port_en keeps all readys low until the first clock after reset
    assign awready = port_en && !busy && !aw_held;
    assign wready  = port_en && !busy && !w_held;
    // Reads wait while any part of a write is pending
    assign arready = port_en && !busy && !aw_held && !w_held && !awvalid && !wvalid;

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign ar_fire   = arvalid && arready;
    assign wr_go     = (aw_held || aw_fire) && (w_held || w_fire);
    assign strb_full = w_held ? &strb_q : &wstrb;
    assign resp_done = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            port_en  <= 1'b0;
            busy     <= 1'b0;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            reg_wr   <= 1'b0;
            reg_rd   <= 1'b0;
            acc_q    <= 1'b0;
            acc_wr_q <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            rvalid   <= 1'b0;
            rresp    <= RESP_OKAY;
        end else begin
            port_en  <= 1'b1;
            // Partial strobes skip the register write but still answer
            reg_wr   <= wr_go && strb_full;
            reg_rd   <= ar_fire;
            acc_q    <= wr_go || ar_fire;
            acc_wr_q <= wr_go;

            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_held <= 1'b1;
                end
                if (w_fire) begin
                    w_held <= 1'b1;
                end
            end

            if (wr_go || ar_fire) begin
                busy <= 1'b1;
            end else if (resp_done) begin
                busy <= 1'b0;
            end

            // Response one cycle after the access strobe
            if (acc_q && acc_wr_q) begin
                bvalid <= 1'b1;
                bresp  <= (reg_wr && reg_err) ? RESP_SLVERR : RESP_OKAY;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (acc_q && !acc_wr_q) begin
                rvalid <= 1'b1;
                rresp  <= reg_err ? RESP_SLVERR : RESP_OKAY;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Address and data capture

    always_ff @(posedge clk_sys) begin
        if (ar_fire) begin
            reg_addr <= aout_reg_e'(araddr);
        end else if (aw_fire) begin
            reg_addr <= aout_reg_e'(awaddr);
        end
        if (w_fire) begin
            reg_wdata <= wdata;
            strb_q    <= wstrb;
        end
        if (acc_q && !acc_wr_q) begin
            rdata <= reg_rdata;
        end
    end

endmodule

//--- src/aout_regs.sv
`include "apu_defs.svh"

module aout_regs
    import apu_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      rst_n_sys,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  aout_reg_e                 reg_addr,
    input  logic [`AXIL_DATA_W-1:0]   reg_wdata,
    output logic [`AXIL_DATA_W-1:0]   reg_rdata,
    output logic                      reg_err,
    input  logic [`FIFO_LEVEL_W-1:0]  fifo_level,
    input  logic                      pwm_running,
    output logic                      fifo_push,
    output logic [`SAMPLE_W-1:0]      fifo_wdata,
    output logic                      csr_enable,
    output logic [`INTERVAL_W-1:0]    csr_interval,
    output logic                      irq
);

    logic [`AXIL_ADDR_W-1:0] addr_raw;
    logic                    addr_bad;
    logic                    wr_ok;
    logic                    fifo_wr;
    logic                    csr_signed;
    logic                    csr_rdy;
    logic [`IRQLEVEL_W-1:0]  csr_irqlevel;

    // ------------------------------------------------------------
    // Decode

    assign addr_raw = reg_addr;
    // Outside the block or not word aligned
    assign addr_bad = (addr_raw >= `AOUT_REG_SPAN) || (addr_raw[1:0] != 2'b00);
    assign reg_err  = (reg_wr || reg_rd) && addr_bad;
    assign wr_ok    = reg_wr && !addr_bad;
    assign fifo_wr  = wr_ok && (reg_addr == REG_FIFO);
    assign csr_rdy  = fifo_level != `FIFO_DEPTH;

    always_comb begin
        reg_rdata = '0;
        if (reg_rd && !addr_bad) begin
            case (reg_addr)
                REG_CSR: begin
                    reg_rdata[0]                  = csr_enable;
                    reg_rdata[1]                  = csr_signed;
                    reg_rdata[2]                  = pwm_running;
                    reg_rdata[3]                  = csr_rdy;
                    reg_rdata[4 +: `FIFO_LEVEL_W] = fifo_level;
                end
                REG_INTERVAL: reg_rdata[`INTERVAL_W-1:0] = csr_interval;
                REG_IRQLEVEL: reg_rdata[`IRQLEVEL_W-1:0] = csr_irqlevel;
                default:      reg_rdata = '0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Control registers and level interrupt

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            csr_enable   <= 1'b0;
            csr_signed   <= 1'b0;
            csr_interval <= '0;
            csr_irqlevel <= '0;
            fifo_push    <= 1'b0;
            irq          <= 1'b0;
        end else begin
            fifo_push <= fifo_wr;
            // Asserted while the FIFO is running low
            irq       <= fifo_level <= csr_irqlevel;
            if (wr_ok) begin
                case (reg_addr)
                    REG_CSR: begin
                        csr_enable <= reg_wdata[0];
                        csr_signed <= reg_wdata[1];
                    end
                    REG_INTERVAL: csr_interval <= reg_wdata[`INTERVAL_W-1:0];
                    REG_IRQLEVEL: csr_irqlevel <= reg_wdata[`IRQLEVEL_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Unsigned samples are offset-binary, flip the MSB to two's complement
    always_ff @(posedge clk_sys) begin
        if (fifo_wr) begin
            fifo_wdata <= reg_wdata[`SAMPLE_W-1:0] ^ {!csr_signed, {(`SAMPLE_W-1){1'b0}}};
        end
    end

endmodule

//--- src/sample_fifo.sv
`include "apu_defs.svh"

module sample_fifo #(
    parameter int WIDTH  = `SAMPLE_W,
    parameter int ADDR_W = `FIFO_ADDR_W
) (
    input  logic              clk_sys,
    input  logic              rst_n_sys,
    input  logic              push,
    input  logic [WIDTH-1:0]  wdata,
    input  logic              pop,
    output logic [WIDTH-1:0]  rdata,
    output logic [ADDR_W:0]   level
);

    localparam int              DEPTH = 1 << ADDR_W;
    localparam logic [ADDR_W:0] FULL  = {1'b1, {ADDR_W{1'b0}}};

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              do_push;
    logic              do_pop;

    // Push when full and pop when empty are dropped
    assign do_push = push && (level != FULL);
    assign do_pop  = pop && (level != '0);

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

    // Read register keeps the last popped sample
    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
        if (do_pop) begin
            rdata <= mem[rd_ptr];
        end
    end

endmodule

//--- src/aout_pwm.sv
`include "apu_defs.svh"

module aout_pwm
    import apu_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      rst_n_sys,
    input  logic                      enable,
    input  logic [`INTERVAL_W-1:0]    interval,
    input  logic [`SAMPLE_W-1:0]      sample,
    input  logic [`FIFO_LEVEL_W-1:0]  level,
    output logic                      pop,
    output logic                      running,
    output logic                      audio
);

    aout_state_e            state;
    logic [`PWM_BITS-1:0]   cnt;
    logic [`INTERVAL_W-1:0] rep;
    logic [`PWM_BITS-1:0]   duty;
    logic                   period_end;

    // Top bits of the sample set the high time of each period
    assign duty       = sample[`SAMPLE_W-1 -: `PWM_BITS];
    assign period_end = &cnt;
    // An empty FIFO leaves the previous sample in place
    assign pop        = (state == FETCH) && (level != '0);
    assign running    = state != IDLE;

    // ------------------------------------------------------------
    // Pacing FSM and period counter

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            state <= IDLE;
            cnt   <= '0;
            rep   <= '0;
            audio <= 1'b0;
        end else begin
            // Registered compare, v high cycles per period
            audio <= (state == PLAY) && (cnt < duty);
            case (state)
                IDLE: begin
                    cnt <= '0;
                    rep <= '0;
                    if (enable) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    cnt   <= '0;
                    rep   <= '0;
                    state <= PLAY;
                end
                PLAY: begin
                    cnt <= cnt + 1'b1;
                    // Decisions only at the end of a full period
                    if (period_end) begin
                        if (!enable) begin
                            state <= IDLE;
                        end else if (rep == interval) begin
                            state <= FETCH;
                        end else begin
                            rep <= rep + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- src/audio_processor.sv
`include "apu_defs.svh"

module audio_processor
    import apu_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        rst_n_sys,
    input  logic [`AXIL_ADDR_W-1:0]     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXIL_DATA_W-1:0]     wdata,
    input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXIL_ADDR_W-1:0]     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`AXIL_DATA_W-1:0]     rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        irq,
    output logic                        audio
);

    logic                     reg_wr;
    logic                     reg_rd;
    aout_reg_e                reg_addr;
    logic [`AXIL_DATA_W-1:0]  reg_wdata;
    logic [`AXIL_DATA_W-1:0]  reg_rdata;
    logic                     reg_err;
    logic                     fifo_push;
    logic [`SAMPLE_W-1:0]     fifo_wdata;
    logic                     fifo_pop;
    logic [`SAMPLE_W-1:0]     fifo_rdata;
    logic [`FIFO_LEVEL_W-1:0] fifo_level;
    logic                     csr_enable;
    logic [`INTERVAL_W-1:0]   csr_interval;
    logic                     pwm_running;

    // ------------------------------------------------------------
    // Bus port and AOUT registers

    axil_slave_port u_port (.*);

    aout_regs u_regs (.*);

    // ------------------------------------------------------------
    // Sample FIFO and generator

    sample_fifo #(
        .WIDTH  (`SAMPLE_W),
        .ADDR_W (`FIFO_ADDR_W)
    ) u_fifo (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .push      (fifo_push),
        .wdata     (fifo_wdata),
        .pop       (fifo_pop),
        .rdata     (fifo_rdata),
        .level     (fifo_level)
    );

    aout_pwm u_pwm (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .enable    (csr_enable),
        .interval  (csr_interval),
        .sample    (fifo_rdata),
        .level     (fifo_level),
        .pop       (fifo_pop),
        .running   (pwm_running),
        .audio     (audio)
    );

endmodule

//--- tb/tb_audio_processor.sv
`include "apu_defs.svh"

module tb_audio_processor
    import apu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // Covers the table and about 60 PWM periods of 257 cycles with margin
    localparam int MAX_CYCLES = 40000;
    localparam int NUM_STEPS  = 19;

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_IRQ
    } op_e;

    typedef struct packed {
        op_e                     op;
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W-1:0] exp_data;
        logic [1:0]              exp_resp;
    } step_t;

    logic                      clk_sys;
    logic                      rst_n_sys;
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      irq;
    logic                      audio;

    int          cycles;
    int          checks;
    int          errors;
    logic [15:0] lfsr;

    // Register accesses, FIFO fill and level interrupt
    step_t steps [NUM_STEPS] = '{
        '{OP_IRQ, 8'h00, 32'h0, 32'h1, 2'b00},
        '{OP_WR,  8'h04, 32'h5a, 32'h0, 2'b00},
        '{OP_RD,  8'h04, 32'h0, 32'h5a, 2'b00},
        '{OP_WR,  8'h08, 32'h3, 32'h0, 2'b00},
        '{OP_RD,  8'h08, 32'h0, 32'h3, 2'b00},
        '{OP_RD,  8'h0c, 32'h0, 32'h0, 2'b00},
        '{OP_WR,  8'h10, 32'h1, 32'h0, 2'b10},
        '{OP_RD,  8'h10, 32'h0, 32'h0, 2'b10},
        '{OP_WR,  8'h00, 32'h0, 32'h0, 2'b00},
        '{OP_WR,  8'h0c, 32'h1234, 32'h0, 2'b00},
        '{OP_WR,  8'h0c, 32'h2345, 32'h0, 2'b00},
        '{OP_WR,  8'h0c, 32'h3456, 32'h0, 2'b00},
        '{OP_WR,  8'h0c, 32'h4567, 32'h0, 2'b00},
        '{OP_WR,  8'h0c, 32'h5678, 32'h0, 2'b00},
        // Full FIFO shows flevel 4 in bits 6:4 and rdy low
        '{OP_RD,  8'h00, 32'h0, 32'(4 << 4), 2'b00},
        '{OP_WR,  8'h08, 32'h2, 32'h0, 2'b00},
        '{OP_IRQ, 8'h00, 32'h0, 32'h0, 2'b00},
        '{OP_WR,  8'h08, 32'h4, 32'h0, 2'b00},
        '{OP_IRQ, 8'h00, 32'h0, 32'h1, 2'b00}
    };

    audio_processor u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Helpers

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [15:0] val);
        val = '0;
        repeat (nbits) begin
            val  = {val[14:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge clk_sys);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = '1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            // Readys are settled well before the next rising edge
            #1;
            aw_done = aw_done || (awvalid && awready);
            w_done  = w_done || (wvalid && wready);
            @(negedge clk_sys);
            awvalid = awvalid && !aw_done;
            wvalid  = wvalid && !w_done;
        end
        while (!bvalid) @(negedge clk_sys);
        resp = bresp;
        @(negedge clk_sys);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic done;
        done = 1'b0;
        @(negedge clk_sys);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!done) begin
            #1;
            done = arready;
            @(negedge clk_sys);
        end
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk_sys);
        data = rdata;
        resp = rresp;
        @(negedge clk_sys);
        rready = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value("write response", 32'(resp), 32'h0);
    endtask

    task automatic wait_running(input logic want);
        logic [31:0] csr;
        logic [1:0]  resp;
        do begin
            axil_read(REG_CSR, csr, resp);
        end while (csr[2] != want);
    endtask

    // Play out what is left in the FIFO at interval 0, then stop
    task automatic drain_fifo();
        logic [31:0] csr;
        logic [1:0]  resp;
        reg_write(REG_CSR, 32'h0);
        wait_running(1'b0);
        reg_write(REG_INTERVAL, 32'h0);
        reg_write(REG_CSR, 32'h1);
        do begin
            axil_read(REG_CSR, csr, resp);
        end while (csr[6:4] != 3'd0);
        reg_write(REG_CSR, 32'h0);
        wait_running(1'b0);
    endtask

    task automatic count_high(input logic align, output int n);
        n = 0;
        if (align) begin
            // Open the window on a rising edge so it spans one whole period
            while (audio) @(negedge clk_sys);
            while (!audio) @(negedge clk_sys);
            n = 1;
        end
        repeat (align ? 255 : 256) begin
            @(negedge clk_sys);
            if (audio) begin
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [15:0] rnd;
        logic [7:0]  interval;
        logic [7:0]  duty;
        logic [15:0] sample;
        int          n;

        checks    = 0;
        errors    = 0;
        lfsr      = 16'd27064;
        rst_n_sys = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        repeat (4) @(negedge clk_sys);
        // Readys, responses, audio and irq all start low
        check_value("outputs in reset",
                    32'({awready, wready, arready, bvalid, rvalid, audio, irq}), 32'h0);
        rst_n_sys = 1'b1;

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR: begin
                    axil_write(steps[i].addr, steps[i].data, resp);
                    check_value($sformatf("bresp of step %0d", i), 32'(resp),
                                32'(steps[i].exp_resp));
                end
                OP_RD: begin
                    axil_read(steps[i].addr, data, resp);
                    check_value($sformatf("rdata of step %0d", i), data, steps[i].exp_data);
                    check_value($sformatf("rresp of step %0d", i), 32'(resp),
                                32'(steps[i].exp_resp));
                end
                default: begin
                    repeat (2) @(negedge clk_sys);
                    check_value($sformatf("irq at step %0d", i), 32'(irq), steps[i].exp_data);
                end
            endcase
        end

        // Signed samples play at the duty of their top byte
        drain_fifo();
        draw_bits(3, rnd);
        interval = {5'b0, rnd[2:0]};
        draw_bits(8, rnd);
        duty = (rnd[7:0] == 8'd0) ? 8'd1 : rnd[7:0];
        draw_bits(8, rnd);
        sample = {duty, rnd[7:0]};
        reg_write(REG_CSR, 32'h2);
        reg_write(REG_INTERVAL, {24'h0, interval});
        repeat (4) reg_write(REG_FIFO, {16'h0, sample});
        reg_write(REG_CSR, 32'h3);
        wait_running(1'b1);
        repeat ((interval + 1) * 256) @(negedge clk_sys);
        count_high(1'b1, n);
        check_value("duty of signed sample", 32'(n), {24'h0, duty});

        // Unsigned zero is mid scale once the MSB is flipped
        drain_fifo();
        reg_write(REG_FIFO, 32'h0);
        reg_write(REG_CSR, 32'h1);
        wait_running(1'b1);
        repeat (256) @(negedge clk_sys);
        count_high(1'b1, n);
        check_value("duty of unsigned zero", 32'(n), 32'd128);

        reg_write(REG_CSR, 32'h0);
        wait_running(1'b0);
        count_high(1'b0, n);
        check_value("audio high cycles after disable", 32'(n), 32'h0);

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/apu_pkg.sv
src/axil_slave_port.sv
src/aout_regs.sv
src/sample_fifo.sv
src/aout_pwm.sv
src/audio_processor.sv
tb/tb_audio_processor.sv

//--- Makefile
TOP := tb_audio_processor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -j 0 -f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

lint:
	verilator --lint-only --timing -f flist.f --top-module audio_processor

clean:
	rm -rf obj_dir
